// ==== common/face_pkg.sv ====
package face_pkg;

  // Basic widths
  localparam int COORD_W = 12;
  localparam int PIX_W   = 8;
  localparam int WIN     = 4;
  localparam int SUM_W   = 16;

  // Entries in the fixed stage table
  localparam int STAGE_TABLE_LEN = 4;

  // One accepted pixel with its raster position
  typedef struct packed {
    logic [COORD_W-1:0] x;
    logic [COORD_W-1:0] y;
    logic [PIX_W-1:0]   gray;
  } pixel_beat_t;

  // Region sums of one 4x4 window
  // x/y name the bottom-right pixel of the window
  typedef struct packed {
    logic [COORD_W-1:0]      x;
    logic [COORD_W-1:0]      y;
    logic signed [SUM_W-1:0] total;
    logic signed [SUM_W-1:0] top;
    logic signed [SUM_W-1:0] bottom;
    logic signed [SUM_W-1:0] left;
    logic signed [SUM_W-1:0] right;
  } window_sums_t;

  // Feature selected by a stage
  typedef enum logic [1:0] {
    FEAT_TOTAL,
    FEAT_TOP_BOTTOM,
    FEAT_LEFT_RIGHT,
    FEAT_RIGHT_LEFT
  } feature_t;

  typedef struct packed {
    feature_t                feature;
    logic signed [SUM_W-1:0] threshold;
  } stage_param_t;

  // A stage passes when feature value >= threshold
  localparam stage_param_t STAGE_TABLE [0:STAGE_TABLE_LEN-1] = '{
    '{feature: FEAT_TOTAL,      threshold: 16'sd800},
    '{feature: FEAT_TOP_BOTTOM, threshold: 16'sd60},
    '{feature: FEAT_LEFT_RIGHT, threshold: -16'sd100},
    '{feature: FEAT_RIGHT_LEFT, threshold: -16'sd300}
  };

  typedef struct packed {
    logic [COORD_W-1:0] x;
    logic [COORD_W-1:0] y;
  } candidate_t;

endpackage

// ==== rtl/pixel_intake.sv ====
`timescale 1ns/1ps

module pixel_intake #(
  parameter int FRAME_WIDTH  = 16,
  parameter int FRAME_HEIGHT = 12
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        i_pixel_strobe,
  input  logic [face_pkg::PIX_W-1:0]  i_pixel,
  input  logic                        i_busy,
  input  logic                        i_fifo_full,
  output logic                        o_pixel_ready,
  output face_pkg::pixel_beat_t       o_beat,
  output logic                        o_beat_valid,
  output logic                        o_frame_end
);

  logic                          accept;
  logic                          last_x;
  logic                          last_y;
  logic                          last_pixel_q;
  logic [face_pkg::COORD_W-1:0]  x_cnt;
  logic [face_pkg::COORD_W-1:0]  y_cnt;

  // Host handshake, strobe only counts while ready
  assign accept = i_pixel_strobe && o_pixel_ready;
  assign last_x = (x_cnt == face_pkg::COORD_W'(FRAME_WIDTH - 1));
  assign last_y = (y_cnt == face_pkg::COORD_W'(FRAME_HEIGHT - 1));

  // Raster counters and ready / frame-end control
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      x_cnt         <= '0;
      y_cnt         <= '0;
      o_pixel_ready <= 1'b0;
      o_beat_valid  <= 1'b0;
      last_pixel_q  <= 1'b0;
      o_frame_end   <= 1'b0;
    end
    else
    begin
      o_beat_valid <= accept;
      // Frame end trails the last pixel by two cycles
      last_pixel_q <= accept && last_x && last_y;
      o_frame_end  <= last_pixel_q;

      if (accept)
      begin
        x_cnt <= last_x ? '0 : x_cnt + 1'b1;
        if (last_x)
          y_cnt <= last_y ? '0 : y_cnt + 1'b1;
      end

      // Drop after each pixel
      // A beat still on its way to the window counts as busy too
      if (accept)
        o_pixel_ready <= 1'b0;
      else
        o_pixel_ready <= !i_busy && !i_fifo_full && !o_beat_valid;
    end
  end

  // Pixel payload with its coordinates
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      o_beat.x    <= x_cnt;
      o_beat.y    <= y_cnt;
      o_beat.gray <= i_pixel;
    end
  end

endmodule

// ==== window_buffer/window_buffer.sv ====
`timescale 1ns/1ps

module window_buffer #(
  parameter int FRAME_WIDTH  = 16,
  parameter int FRAME_HEIGHT = 12
) (
  input  logic                   clk,
  input  logic                   reset,
  input  face_pkg::pixel_beat_t  i_beat,
  input  logic                   i_beat_valid,
  output face_pkg::window_sums_t o_sums,
  output logic                   o_window_valid
);

  localparam int WIN   = face_pkg::WIN;
  localparam int PIX_W = face_pkg::PIX_W;
  localparam int SUM_W = face_pkg::SUM_W;
  localparam int XA_W  = (FRAME_WIDTH > 1) ? $clog2(FRAME_WIDTH) : 1;

  // line_buf[0] holds the row just above, line_buf[WIN-2] the oldest
  logic [PIX_W-1:0]        line_buf [0:WIN-2][0:FRAME_WIDTH-1];
  // Window rows 0 (top) .. WIN-1 (current row), columns 0 (left) .. WIN-1
  logic [PIX_W-1:0]        win      [0:WIN-1][0:WIN-1];
  logic [PIX_W-1:0]        next_win [0:WIN-1][0:WIN-1];
  logic [PIX_W-1:0]        col      [0:WIN-1];
  logic [XA_W-1:0]         xa;
  logic                    in_frame;
  logic signed [SUM_W-1:0] sum_total;
  logic signed [SUM_W-1:0] sum_top;
  logic signed [SUM_W-1:0] sum_bottom;
  logic signed [SUM_W-1:0] sum_left;
  logic signed [SUM_W-1:0] sum_right;

  assign xa = i_beat.x[XA_W-1:0];

  // Incoming column, oldest row first
  always_comb
  begin
    for (int r = 0; r < WIN - 1; r++)
      col[r] = line_buf[WIN-2-r][xa];
    col[WIN-1] = i_beat.gray;
  end

  // Window after this beat, shifted left by one column
  always_comb
  begin
    for (int r = 0; r < WIN; r++)
    begin
      for (int c = 0; c < WIN - 1; c++)
        next_win[r][c] = win[r][c+1];
      next_win[r][WIN-1] = col[r];
    end
  end

  // Region sums of the shifted window
  always_comb
  begin
    sum_total  = '0;
    sum_top    = '0;
    sum_bottom = '0;
    sum_left   = '0;
    sum_right  = '0;
    for (int r = 0; r < WIN; r++)
    begin
      for (int c = 0; c < WIN; c++)
      begin
        sum_total = sum_total + SUM_W'(next_win[r][c]);
        if (r < WIN / 2)
          sum_top = sum_top + SUM_W'(next_win[r][c]);
        else
          sum_bottom = sum_bottom + SUM_W'(next_win[r][c]);
        if (c < WIN / 2)
          sum_left = sum_left + SUM_W'(next_win[r][c]);
        else
          sum_right = sum_right + SUM_W'(next_win[r][c]);
      end
    end
  end

  // Whole 4x4 inside this frame, stale rows of an older frame are excluded
  assign in_frame = (i_beat.x >= face_pkg::COORD_W'(WIN - 1))
                 && (i_beat.x <  face_pkg::COORD_W'(FRAME_WIDTH))
                 && (i_beat.y >= face_pkg::COORD_W'(WIN - 1))
                 && (i_beat.y <  face_pkg::COORD_W'(FRAME_HEIGHT));

  always_ff @(posedge clk)
  begin
    if (reset)
      o_window_valid <= 1'b0;
    else
      o_window_valid <= i_beat_valid && in_frame;
  end

  // Line buffers, window and sums move together on each beat
  always_ff @(posedge clk)
  begin
    if (i_beat_valid)
    begin
      line_buf[0][xa] <= i_beat.gray;
      for (int k = 1; k < WIN - 1; k++)
        line_buf[k][xa] <= line_buf[k-1][xa];
      win           <= next_win;
      o_sums.x      <= i_beat.x;
      o_sums.y      <= i_beat.y;
      o_sums.total  <= sum_total;
      o_sums.top    <= sum_top;
      o_sums.bottom <= sum_bottom;
      o_sums.left   <= sum_left;
      o_sums.right  <= sum_right;
    end
  end

endmodule

// ==== cascade/stage_rom.sv ====
`timescale 1ns/1ps

module stage_rom #(
  parameter int NUM_STAGES = 4
) (
  input  logic                   clk,
  input  logic [((NUM_STAGES > 1) ? $clog2(NUM_STAGES) : 1)-1:0] i_stage_index,
  output face_pkg::stage_param_t o_stage
);

  localparam int IDX_W = (NUM_STAGES > 1) ? $clog2(NUM_STAGES) : 1;

  logic [IDX_W-1:0] rd_index;

  // Indexes past the last stage fall back to stage 0
  always_comb
  begin
    if (int'(i_stage_index) < NUM_STAGES)
      rd_index = i_stage_index;
    else
      rd_index = '0;
  end

  // One-cycle table read
  always_ff @(posedge clk)
  begin
    o_stage <= face_pkg::STAGE_TABLE[rd_index];
  end

endmodule

// ==== cascade/cascade_classifier.sv ====
`timescale 1ns/1ps

module cascade_classifier #(
  parameter int NUM_STAGES = 4
) (
  input  logic                   clk,
  input  logic                   reset,
  input  face_pkg::window_sums_t i_sums,
  input  logic                   i_window_valid,
  output logic                   o_busy,
  output logic                   o_push,
  output face_pkg::candidate_t   o_candidate
);

  localparam int IDX_W = (NUM_STAGES > 1) ? $clog2(NUM_STAGES) : 1;
  localparam int SUM_W = face_pkg::SUM_W;

  logic                    eval_active;
  logic [IDX_W-1:0]        stage_idx;
  logic [IDX_W-1:0]        rom_index;
  face_pkg::stage_param_t  rom_stage;
  face_pkg::window_sums_t  sums_q;
  logic signed [SUM_W-1:0] feat_value;
  logic                    stage_pass;
  logic                    last_stage;

  // Fetch one stage ahead of evaluation
  // Stage 0 is fetched in the cycle the window arrives
  assign rom_index = eval_active ? IDX_W'(stage_idx + 1'b1) : '0;

  stage_rom #(
    .NUM_STAGES (NUM_STAGES)
  ) u_stage_rom (
    .clk           (clk),
    .i_stage_index (rom_index),
    .o_stage       (rom_stage)
  );

  // Feature value picked by the current stage
  always_comb
  begin
    case (rom_stage.feature)
      face_pkg::FEAT_TOTAL:      feat_value = sums_q.total;
      face_pkg::FEAT_TOP_BOTTOM: feat_value = sums_q.top - sums_q.bottom;
      face_pkg::FEAT_LEFT_RIGHT: feat_value = sums_q.left - sums_q.right;
      default:                   feat_value = sums_q.right - sums_q.left;
    endcase
  end

  // Signed compare
  assign stage_pass = (feat_value >= rom_stage.threshold);
  assign last_stage = (stage_idx == IDX_W'(NUM_STAGES - 1));

  // Stage sequencing, early exit on first failure
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      eval_active <= 1'b0;
      stage_idx   <= '0;
    end
    else if (i_window_valid)
    begin
      eval_active <= 1'b1;
      stage_idx   <= '0;
    end
    else if (eval_active)
    begin
      if (!stage_pass || last_stage)
      begin
        eval_active <= 1'b0;
        stage_idx   <= '0;
      end
      else
        stage_idx <= stage_idx + 1'b1;
    end
  end

  // Held for the whole evaluation
  always_ff @(posedge clk)
  begin
    if (i_window_valid)
      sums_q <= i_sums;
  end

  // Busy also covers the cycle the window shows up
  assign o_busy = i_window_valid || eval_active;

  // Push in the same cycle the last stage passes
  assign o_push        = eval_active && last_stage && stage_pass;
  assign o_candidate.x = sums_q.x;
  assign o_candidate.y = sums_q.y;

endmodule

// ==== rtl/result_fifo.sv ====
`timescale 1ns/1ps

module result_fifo #(
  parameter int RESULT_DEPTH = 8
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         i_push,
  input  face_pkg::candidate_t         i_candidate,
  input  logic                         i_result_sent,
  output logic                         o_full,
  output logic                         o_result_valid,
  output logic [face_pkg::COORD_W-1:0] o_result_data,
  output logic                         o_result_end
);

  localparam int PTR_W = (RESULT_DEPTH > 1) ? $clog2(RESULT_DEPTH) : 1;
  localparam int CNT_W = $clog2(RESULT_DEPTH + 1);

  face_pkg::candidate_t mem [0:RESULT_DEPTH-1];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [CNT_W-1:0]     count;
  // Low while the x word is shown, high for the y word
  logic                 half_sel;
  logic                 do_push;
  logic                 take_word;
  logic                 do_pop;

  assign do_push   = i_push && !o_full;
  assign take_word = i_result_sent && o_result_valid;
  // Entry leaves once its y word is taken
  assign do_pop    = take_word && half_sel;

  // Pointers, occupancy and word select
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      half_sel <= 1'b0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == PTR_W'(RESULT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == PTR_W'(RESULT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase

      if (take_word)
        half_sel <= !half_sel;
    end
  end

  // Candidate storage
  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= i_candidate;
  end

  assign o_full         = (count == CNT_W'(RESULT_DEPTH));
  assign o_result_valid = (count != '0);
  assign o_result_end   = (count == '0);

  // x word first, then y
  assign o_result_data = half_sel ? mem[rd_ptr].y : mem[rd_ptr].x;

endmodule

// ==== rtl/face_detector_top.sv ====
`timescale 1ns/1ps

module face_detector_top #(
  parameter int FRAME_WIDTH  = 16,
  parameter int FRAME_HEIGHT = 12,
  parameter int NUM_STAGES   = 4,
  parameter int RESULT_DEPTH = 8
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         i_pixel_strobe,
  input  logic [face_pkg::PIX_W-1:0]   i_pixel,
  input  logic                         i_result_sent,
  output logic                         o_pixel_ready,
  output logic                         o_frame_end,
  output logic                         o_result_valid,
  output logic [face_pkg::COORD_W-1:0] o_result_data,
  output logic                         o_result_end
);

  // Pixel path
  face_pkg::pixel_beat_t  beat;
  logic                   beat_valid;
  face_pkg::window_sums_t sums;
  logic                   window_valid;

  // Classifier and result path
  logic                   cascade_busy;
  logic                   push;
  face_pkg::candidate_t   candidate;
  logic                   fifo_full;

  pixel_intake #(
    .FRAME_WIDTH  (FRAME_WIDTH),
    .FRAME_HEIGHT (FRAME_HEIGHT)
  ) u_pixel_intake (
    .clk            (clk),
    .reset          (reset),
    .i_pixel_strobe (i_pixel_strobe),
    .i_pixel        (i_pixel),
    .i_busy         (cascade_busy),
    .i_fifo_full    (fifo_full),
    .o_pixel_ready  (o_pixel_ready),
    .o_beat         (beat),
    .o_beat_valid   (beat_valid),
    .o_frame_end    (o_frame_end)
  );

  window_buffer #(
    .FRAME_WIDTH  (FRAME_WIDTH),
    .FRAME_HEIGHT (FRAME_HEIGHT)
  ) u_window_buffer (
    .clk            (clk),
    .reset          (reset),
    .i_beat         (beat),
    .i_beat_valid   (beat_valid),
    .o_sums         (sums),
    .o_window_valid (window_valid)
  );

  cascade_classifier #(
    .NUM_STAGES (NUM_STAGES)
  ) u_cascade_classifier (
    .clk            (clk),
    .reset          (reset),
    .i_sums         (sums),
    .i_window_valid (window_valid),
    .o_busy         (cascade_busy),
    .o_push         (push),
    .o_candidate    (candidate)
  );

  result_fifo #(
    .RESULT_DEPTH (RESULT_DEPTH)
  ) u_result_fifo (
    .clk            (clk),
    .reset          (reset),
    .i_push         (push),
    .i_candidate    (candidate),
    .i_result_sent  (i_result_sent),
    .o_full         (fifo_full),
    .o_result_valid (o_result_valid),
    .o_result_data  (o_result_data),
    .o_result_end   (o_result_end)
  );

endmodule

// ==== sim/tb_face_model.svh ====
`ifndef TB_FACE_MODEL_SVH
`define TB_FACE_MODEL_SVH

// Frame patterns
localparam int PAT_DARK     = 0;
localparam int PAT_BLOCKS   = 1;
localparam int PAT_RANDOM   = 2;
localparam int PAT_GRADIENT = 3;

// Main random stream, pixels and host gaps
int unsigned lcg_state = 32'd35;

function automatic int unsigned lcg_next(input int unsigned state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// Upper bits only, low bits of an LCG repeat quickly
function automatic int rand_below(input int limit);
  lcg_state = lcg_next(lcg_state);
  return int'(lcg_state >> 16) % limit;
endfunction

task automatic make_frame(input int pattern);
  for (int y = 0; y < FRAME_HEIGHT; y++)
  begin
    for (int x = 0; x < FRAME_WIDTH; x++)
    begin
      case (pattern)
        PAT_DARK:   frame[y][x] = 8'd0;
        // Bright bands on rows 0-1 and 6-7, broken every 8 columns
        PAT_BLOCKS: frame[y][x] = ((y % 6) < 2 && (x % 8) < 5) ? 8'd230 : 8'd12;
        PAT_RANDOM: frame[y][x] = 8'(rand_below(256));
        // Darker toward the bottom, every window passes
        default:    frame[y][x] = 8'(250 - 20 * y);
      endcase
    end
  end
endtask

// Cascade decision for the window whose bottom-right pixel is (x, y)
function automatic bit window_is_candidate(input int x, input int y);
  int total;
  int top;
  int bottom;
  int left;
  int right;
  int value;
  face_pkg::stage_param_t stage;
  total  = 0;
  top    = 0;
  bottom = 0;
  left   = 0;
  right  = 0;
  for (int r = y - face_pkg::WIN + 1; r <= y; r++)
  begin
    for (int c = x - face_pkg::WIN + 1; c <= x; c++)
    begin
      total += frame[r][c];
      // Upper two rows against lower two
      if (r < y - 1)
        top += frame[r][c];
      else
        bottom += frame[r][c];
      if (c < x - 1)
        left += frame[r][c];
      else
        right += frame[r][c];
    end
  end
  for (int s = 0; s < NUM_STAGES; s++)
  begin
    stage = face_pkg::STAGE_TABLE[s];
    case (stage.feature)
      face_pkg::FEAT_TOTAL:      value = total;
      face_pkg::FEAT_TOP_BOTTOM: value = top - bottom;
      face_pkg::FEAT_LEFT_RIGHT: value = left - right;
      default:                   value = right - left;
    endcase
    // Early reject
    if (value < int'(stage.threshold))
      return 1'b0;
  end
  return 1'b1;
endfunction

// x word then y word per candidate, raster order
task automatic queue_expected();
  for (int y = face_pkg::WIN - 1; y < FRAME_HEIGHT; y++)
  begin
    for (int x = face_pkg::WIN - 1; x < FRAME_WIDTH; x++)
    begin
      if (window_is_candidate(x, y))
      begin
        expected_words.push_back(face_pkg::COORD_W'(x));
        expected_words.push_back(face_pkg::COORD_W'(y));
      end
    end
  end
endtask

`endif

// ==== sim/tb_face_detector.sv ====
`timescale 1ns/1ps

module tb_face_detector;

  localparam int FRAME_WIDTH  = 16;
  localparam int FRAME_HEIGHT = 12;
  localparam int NUM_STAGES   = 4;
  localparam int RESULT_DEPTH = 8;
  localparam int PIXELS       = FRAME_WIDTH * FRAME_HEIGHT;
  localparam int MAX_GAP      = 3;
  localparam int STALL_CYCLES = 60;
  // Per pixel: handshake, window latency, full cascade, host gap
  localparam int PIXEL_CYCLES = NUM_STAGES + 3 + 4 + MAX_GAP;
  // Per frame: up to two words per pixel, each with a read delay
  localparam int READ_CYCLES  = 2 * PIXELS * (MAX_GAP + 2);
  // Five frames plus the held-read stall
  localparam int TIMEOUT_LIMIT = 5 * (PIXELS * PIXEL_CYCLES + READ_CYCLES)
                               + STALL_CYCLES + 2000;

  logic                         clk;
  logic                         reset;
  logic                         i_pixel_strobe;
  logic [face_pkg::PIX_W-1:0]   i_pixel;
  logic                         i_result_sent;
  logic                         o_pixel_ready;
  logic                         o_frame_end;
  logic                         o_result_valid;
  logic [face_pkg::COORD_W-1:0] o_result_data;
  logic                         o_result_end;

  logic [face_pkg::PIX_W-1:0]   frame [0:FRAME_HEIGHT-1][0:FRAME_WIDTH-1];
  logic [face_pkg::COORD_W-1:0] expected_words [$];
  logic [face_pkg::COORD_W-1:0] exp_word;
  string                        test_name;
  int                           test_errors;
  int                           total_errors;
  int                           tests_run;
  int                           tests_failed;
  int                           cycle_count;
  int                           frame_end_count;
  int                           accepted_count;
  int                           read_wait;
  int unsigned                  read_state;
  bit                           read_hold;
  bit                           random_reads;

  `include "tb_face_model.svh"

  face_detector_top #(
    .FRAME_WIDTH  (FRAME_WIDTH),
    .FRAME_HEIGHT (FRAME_HEIGHT),
    .NUM_STAGES   (NUM_STAGES),
    .RESULT_DEPTH (RESULT_DEPTH)
  ) u_face_detector_top (
    .clk            (clk),
    .reset          (reset),
    .i_pixel_strobe (i_pixel_strobe),
    .i_pixel        (i_pixel),
    .i_result_sent  (i_result_sent),
    .o_pixel_ready  (o_pixel_ready),
    .o_frame_end    (o_frame_end),
    .o_result_valid (o_result_valid),
    .o_result_data  (o_result_data),
    .o_result_end   (o_result_end)
  );

  always #20 clk = ~clk;

  task automatic report_mismatch(input string what, input int expected, input int actual);
    $display("FAILED %s: %s expected %0d actual %0d", test_name, what, expected, actual);
    test_errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("ERROR in %s: %s", test_name, msg);
    test_errors++;
  endtask

  // Run limit
  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_LIMIT)
    begin
      $display("Run stopped after %0d cycles, test %s never finished", cycle_count, test_name);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // Frame end pulses, only once a whole frame is in
  always @(posedge clk)
  begin
    if (!reset && o_frame_end)
    begin
      frame_end_count++;
      if (accepted_count == 0 || accepted_count % PIXELS != 0)
        report_problem("frame end pulse came before the last pixel of the frame");
    end
  end

  // Result reader, compares each taken word with the model queue
  always @(posedge clk)
  begin
    if (reset)
      read_wait = 0;
    else if (i_result_sent && o_result_valid)
    begin
      if (expected_words.size() == 0)
        report_problem($sformatf("result word %0d arrived with none expected", o_result_data));
      else
      begin
        exp_word = expected_words.pop_front();
        if (o_result_data !== exp_word)
          report_mismatch("result word", exp_word, o_result_data);
      end
      i_result_sent <= 1'b0;
      read_state = lcg_next(read_state);
      read_wait  = random_reads ? int'(read_state >> 16) % (MAX_GAP + 1) : 0;
    end
    else if (read_wait > 0)
      read_wait = read_wait - 1;
    else if (o_result_valid && !read_hold)
      i_result_sent <= 1'b1;
  end

  // Host side, strobe raised only after ready is seen high
  task automatic send_frame(input bit use_gaps);
    int idx;
    int gap;
    idx = 0;
    gap = 0;
    while (idx < PIXELS)
    begin
      @(posedge clk);
      if (i_pixel_strobe && o_pixel_ready)
      begin
        idx++;
        accepted_count <= accepted_count + 1;
        i_pixel_strobe <= 1'b0;
        gap = use_gaps ? rand_below(MAX_GAP + 1) : 0;
      end
      else if (gap > 0)
        gap--;
      else if (!i_pixel_strobe && o_pixel_ready)
      begin
        i_pixel_strobe <= 1'b1;
        i_pixel        <= frame[idx / FRAME_WIDTH][idx % FRAME_WIDTH];
      end
    end
  endtask

  // Reads resume once the intake has sat stalled on a full FIFO
  task automatic release_after_stall();
    int run;
    run = 0;
    while (run < STALL_CYCLES)
    begin
      @(posedge clk);
      if (!o_pixel_ready && o_result_valid)
        run++;
      else
        run = 0;
    end
    read_hold <= 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    test_errors     = 0;
    frame_end_count = 0;
  endtask

  // Idle pipeline and empty FIFO for a few cycles ends a frame test
  task automatic drain_and_check();
    int idle;
    idle = 0;
    while (idle < 3)
    begin
      @(posedge clk);
      if (o_pixel_ready && o_result_end)
        idle++;
      else
        idle = 0;
    end
    if (expected_words.size() != 0)
      report_problem($sformatf("%0d expected result words never arrived",
                               expected_words.size()));
    expected_words.delete();
    if (frame_end_count != 1)
      report_mismatch("frame end pulses", 1, frame_end_count);
  endtask

  task automatic end_test();
    if (test_errors == 0)
      $display("PASS %s", test_name);
    else
    begin
      $display("FAIL %s with %0d errors", test_name, test_errors);
      tests_failed++;
    end
    tests_run++;
    total_errors += test_errors;
  endtask

  task automatic run_frame(input string name, input int pattern, input bit use_gaps);
    start_test(name);
    make_frame(pattern);
    queue_expected();
    send_frame(use_gaps);
    drain_and_check();
    end_test();
  endtask

  initial
  begin
    int wait_cycles;
    clk            = 1'b0;
    reset          = 1'b1;
    i_pixel_strobe = 1'b0;
    i_pixel        = '0;
    i_result_sent  = 1'b0;
    read_hold      = 1'b0;
    random_reads   = 1'b0;
    // Read delays get their own stream, seeded from the main one
    read_state     = 32'(rand_below(65536));

    start_test("reset_state");
    repeat (10) @(posedge clk);
    if (o_pixel_ready !== 1'b0)
      report_mismatch("ready in reset", 0, o_pixel_ready);
    reset <= 1'b0;
    wait_cycles = 0;
    do
    begin
      @(posedge clk);
      wait_cycles++;
    end
    while (o_pixel_ready !== 1'b1 && wait_cycles < 5);
    if (o_pixel_ready !== 1'b1)
      report_problem("pixel ready never rose after reset");
    if (o_result_valid !== 1'b0)
      report_mismatch("result valid", 0, o_result_valid);
    if (o_result_end !== 1'b1)
      report_mismatch("result end", 1, o_result_end);
    end_test();

    run_frame("dark_frame", PAT_DARK, 1'b0);
    run_frame("bright_blocks", PAT_BLOCKS, 1'b0);
    random_reads <= 1'b1;
    run_frame("random_frame", PAT_RANDOM, 1'b1);

    // Reads held until the FIFO has filled and stopped the intake
    start_test("back_pressure");
    make_frame(PAT_GRADIENT);
    queue_expected();
    read_hold <= 1'b1;
    fork
      send_frame(1'b0);
      release_after_stall();
    join
    drain_and_check();
    end_test();

    // Model counts from (0,0) again, so a match shows the restart
    run_frame("second_frame_restart", PAT_BLOCKS, 1'b1);

    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
             total_errors);
    if (tests_failed == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+sim
common/face_pkg.sv
rtl/pixel_intake.sv
window_buffer/window_buffer.sv
cascade/stage_rom.sv
cascade/cascade_classifier.sv
rtl/result_fifo.sv
rtl/face_detector_top.sv
sim/tb_face_detector.sv
